//--- cpu_bus_pkg.sv
package cpu_bus_pkg;

    // Data and address widths of the memory port
    localparam int WORD_W = 32;
    localparam int ADDR_W = 32;

    // Byte stride between consecutive words
    localparam int WORD_BYTES = WORD_W / 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

endpackage

//--- exec_unit.sv
module exec_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  cpu_bus_pkg::word_t issue_word,
    input  cpu_bus_pkg::addr_t issue_pc,
    output logic               issue_ready,
    output logic               redirect,
    output cpu_bus_pkg::addr_t redirect_pc,
    output logic               active,
    output cpu_bus_pkg::word_t register_v0
);

    mips_isa_pkg::instr_u ins;

    cpu_bus_pkg::word_t regs [1:31];
    cpu_bus_pkg::word_t rs_val;
    cpu_bus_pkg::word_t rt_val;
    cpu_bus_pkg::word_t wr_data;
    cpu_bus_pkg::word_t imm_sext;
    cpu_bus_pkg::word_t imm_zext;
    cpu_bus_pkg::addr_t next_pc;
    logic [4:0]         wr_idx;
    logic               wr_en;
    logic               is_jr;
    logic               accept;
    logic               halt;
    logic               started;

    assign ins = issue_word;

    // rs and rt sit in the same bits in both formats
    assign rs_val = (ins.r.rs == 5'd0) ? '0 : regs[ins.r.rs];
    assign rt_val = (ins.r.rt == 5'd0) ? '0 : regs[ins.r.rt];

    assign imm_sext = {{16{ins.i.imm[15]}}, ins.i.imm};
    assign imm_zext = {16'h0000, ins.i.imm};

    assign issue_ready = active;
    assign accept      = issue_valid && issue_ready;
    assign next_pc     = issue_pc + cpu_bus_pkg::addr_t'(cpu_bus_pkg::WORD_BYTES);

    // JR to zero ends the program
    assign halt = accept && is_jr && (rs_val == '0);

    // A jump to the next word needs no flush
    assign redirect    = accept && is_jr && (rs_val != '0) && (rs_val != next_pc);
    assign redirect_pc = rs_val;

    assign register_v0 = regs[2];

    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = ins.r.rd;
        wr_data = '0;
        is_jr   = 1'b0;
        if (ins.r.opcode == mips_isa_pkg::op_special) begin
            wr_en = 1'b1;
            case (ins.r.funct)
                mips_isa_pkg::fn_addu: wr_data = rs_val + rt_val;
                mips_isa_pkg::fn_subu: wr_data = rs_val - rt_val;
                mips_isa_pkg::fn_and:  wr_data = rs_val & rt_val;
                mips_isa_pkg::fn_or:   wr_data = rs_val | rt_val;
                mips_isa_pkg::fn_slt:  wr_data = ($signed(rs_val) < $signed(rt_val)) ? 32'd1 : 32'd0;
                mips_isa_pkg::fn_sltu: wr_data = (rs_val < rt_val) ? 32'd1 : 32'd0;
                mips_isa_pkg::fn_sll:  wr_data = rt_val << ins.r.shamt;
                mips_isa_pkg::fn_srl:  wr_data = rt_val >> ins.r.shamt;
                mips_isa_pkg::fn_jr: begin
                    wr_en = 1'b0;
                    is_jr = 1'b1;
                end
                default: wr_en = 1'b0;
            endcase
        end else begin
            wr_en  = 1'b1;
            wr_idx = ins.i.rt;
            case (ins.i.opcode)
                mips_isa_pkg::op_addiu: wr_data = rs_val + imm_sext;
                mips_isa_pkg::op_ori:   wr_data = rs_val | imm_zext;
                mips_isa_pkg::op_lui:   wr_data = {ins.i.imm, 16'h0000};
                // Anything else retires as a no-op
                default:                wr_en = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (accept && wr_en && (wr_idx != 5'd0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Active rises once after reset and falls for good on halt
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started <= 1'b0;
            active  <= 1'b0;
        end else if (!started) begin
            started <= 1'b1;
            active  <= 1'b1;
        end else if (halt) begin
            active <= 1'b0;
        end
    end

endmodule

//--- fetch_unit.sv
module fetch_unit #(
    parameter cpu_bus_pkg::addr_t RESET_VECTOR = 32'h0000_0004
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               waitrequest,
    input  cpu_bus_pkg::word_t readdata,
    input  logic               fetch_ready,
    input  logic               redirect,
    input  cpu_bus_pkg::addr_t redirect_pc,
    input  logic               active,
    output cpu_bus_pkg::addr_t address,
    output logic               read,
    output logic               fetch_valid,
    output cpu_bus_pkg::word_t fetch_word,
    output cpu_bus_pkg::addr_t fetch_pc
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_READ = 2'd1;
    localparam logic [1:0] S_HOLD = 2'd2;

    logic [1:0]         state;
    cpu_bus_pkg::addr_t pc;
    cpu_bus_pkg::addr_t redir_pc;
    logic               busy;
    logic               stale;
    logic               live;
    logic               may_start;

    // No new reads once the core has run and halted
    assign may_start = active || !live;

    // A read already on the bus stays up until it completes
    assign read        = (state == S_READ) && (busy || may_start);
    assign address     = pc;
    assign fetch_valid = (state == S_HOLD);
    assign fetch_pc    = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            pc    <= RESET_VECTOR;
            busy  <= 1'b0;
            stale <= 1'b0;
            live  <= 1'b0;
        end else begin
            if (active) begin
                live <= 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (redirect) begin
                        pc <= redirect_pc;
                    end
                    if (may_start) begin
                        state <= S_READ;
                    end
                end
                S_READ: begin
                    if (!read) begin
                        state <= S_IDLE;
                    end else if (!waitrequest) begin
                        busy  <= 1'b0;
                        stale <= 1'b0;
                        // Drop the word and restart at the new target
                        if (redirect) begin
                            pc <= redirect_pc;
                        end else if (stale) begin
                            pc <= redir_pc;
                        end else begin
                            state <= S_HOLD;
                        end
                    end else begin
                        busy <= 1'b1;
                        if (redirect) begin
                            stale <= 1'b1;
                        end
                    end
                end
                S_HOLD: begin
                    if (redirect) begin
                        pc    <= redirect_pc;
                        state <= S_READ;
                    end else if (fetch_ready) begin
                        pc    <= pc + cpu_bus_pkg::addr_t'(cpu_bus_pkg::WORD_BYTES);
                        state <= S_READ;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Redirect target parked until the stale read finishes
    always_ff @(posedge clk) begin
        if (state == S_READ && read && waitrequest && redirect) begin
            redir_pc <= redirect_pc;
        end
        if (state == S_READ && read && !waitrequest) begin
            fetch_word <= readdata;
        end
    end

endmodule

//--- flist.f
cpu_bus_pkg.sv
mips_isa_pkg.sv
fetch_unit.sv
instr_queue.sv
exec_unit.sv
mips_cpu.sv
tb_clock_gen.sv
tb_avalon_ram.sv
tb_checker.sv
mips_cpu_tb.sv

//--- instr_queue.sv
module instr_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               fetch_valid,
    input  cpu_bus_pkg::word_t fetch_word,
    input  cpu_bus_pkg::addr_t fetch_pc,
    input  logic               issue_ready,
    output logic               fetch_ready,
    output logic               issue_valid,
    output cpu_bus_pkg::word_t issue_word,
    output cpu_bus_pkg::addr_t issue_pc
);

    localparam int IDX_W = $clog2(QUEUE_DEPTH);

    cpu_bus_pkg::word_t word_mem [QUEUE_DEPTH];
    cpu_bus_pkg::addr_t pc_mem   [QUEUE_DEPTH];

    // Extra top bit tells full from empty
    logic [IDX_W:0] wr_ptr;
    logic [IDX_W:0] rd_ptr;
    logic           full;
    logic           empty;
    logic           push;
    logic           pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[IDX_W] != rd_ptr[IDX_W]) &&
                   (wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);

    assign fetch_ready = !full;
    assign issue_valid = !empty;
    assign issue_word  = word_mem[rd_ptr[IDX_W-1:0]];
    assign issue_pc    = pc_mem[rd_ptr[IDX_W-1:0]];

    assign push = fetch_valid && fetch_ready;
    assign pop  = issue_valid && issue_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            // Everything queued is on the wrong path
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            word_mem[wr_ptr[IDX_W-1:0]] <= fetch_word;
            pc_mem[wr_ptr[IDX_W-1:0]]   <= fetch_pc;
        end
    end

endmodule

//--- mips_cpu.sv
module mips_cpu #(
    parameter cpu_bus_pkg::addr_t RESET_VECTOR = 32'h0000_0004,
    parameter int                 QUEUE_DEPTH  = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               waitrequest,
    input  cpu_bus_pkg::word_t readdata,
    output logic               active,
    output cpu_bus_pkg::word_t register_v0,
    output cpu_bus_pkg::addr_t address,
    output logic               read
);

    logic               fetch_valid;
    logic               fetch_ready;
    cpu_bus_pkg::word_t fetch_word;
    cpu_bus_pkg::addr_t fetch_pc;

    logic               issue_valid;
    logic               issue_ready;
    cpu_bus_pkg::word_t issue_word;
    cpu_bus_pkg::addr_t issue_pc;

    logic               redirect;
    cpu_bus_pkg::addr_t redirect_pc;

    fetch_unit #(
        .RESET_VECTOR(RESET_VECTOR)
    ) u_fetch (
        .clk(clk),
        .rst_n(rst_n),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .fetch_ready(fetch_ready),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .active(active),
        .address(address),
        .read(read),
        .fetch_valid(fetch_valid),
        .fetch_word(fetch_word),
        .fetch_pc(fetch_pc)
    );

    // A taken JR empties the queue on the same edge
    instr_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk(clk),
        .rst_n(rst_n),
        .flush(redirect),
        .fetch_valid(fetch_valid),
        .fetch_word(fetch_word),
        .fetch_pc(fetch_pc),
        .issue_ready(issue_ready),
        .fetch_ready(fetch_ready),
        .issue_valid(issue_valid),
        .issue_word(issue_word),
        .issue_pc(issue_pc)
    );

    exec_unit u_exec (
        .clk(clk),
        .rst_n(rst_n),
        .issue_valid(issue_valid),
        .issue_word(issue_word),
        .issue_pc(issue_pc),
        .issue_ready(issue_ready),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .active(active),
        .register_v0(register_v0)
    );

endmodule

//--- mips_cpu_tb.sv
module mips_cpu_tb;

    localparam int NTESTS = 8;
    localparam logic [4:0] V0 = 5'd2;
    localparam logic [4:0] T0 = 5'd8;
    localparam logic [4:0] T1 = 5'd9;
    localparam logic [4:0] T2 = 5'd10;
    localparam logic [4:0] T3 = 5'd11;

    logic               clk;
    logic               rst_n;
    logic               waitrequest;
    cpu_bus_pkg::word_t readdata;
    logic               active;
    cpu_bus_pkg::word_t register_v0;
    cpu_bus_pkg::addr_t address;
    logic               read;
    logic               stall_bit;
    logic               load_en;
    logic [5:0]         load_addr;
    cpu_bus_pkg::word_t load_word;
    cpu_bus_pkg::word_t exp_v0;
    logic [127:0]       test_name;
    logic               done;
    int                 mismatches;
    int                 halt_errors;
    int                 bus_errors;
    int                 timeouts;
    logic [31:0]        lfsr = 32'h3716_e9de;

    cpu_bus_pkg::word_t prog_tab [NTESTS][8];
    cpu_bus_pkg::word_t exp_tab  [NTESTS];
    logic [127:0]       name_tab [NTESTS];

    tb_clock_gen #(.PERIOD(40)) clk_gen (.clk(clk));

    mips_cpu #(
        .RESET_VECTOR(32'h0000_0004),
        .QUEUE_DEPTH(4)
    ) dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .active(active),
        .register_v0(register_v0),
        .address(address),
        .read(read)
    );

    tb_avalon_ram ram (
        .clk(clk),
        .address(address),
        .read(read),
        .stall_bit(stall_bit),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_word(load_word),
        .waitrequest(waitrequest),
        .readdata(readdata)
    );

    tb_checker chk (
        .clk(clk),
        .rst_n(rst_n),
        .active(active),
        .read(read),
        .waitrequest(waitrequest),
        .address(address),
        .register_v0(register_v0),
        .exp_v0(exp_v0),
        .test_name(test_name),
        .done(done),
        .mismatches(mismatches),
        .halt_errors(halt_errors),
        .bus_errors(bus_errors)
    );

    // Right-shifting Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic cpu_bus_pkg::word_t enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                                 input logic [4:0] rd, input logic [4:0] shamt,
                                                 input logic [5:0] funct);
        return {mips_isa_pkg::op_special, rs, rt, rd, shamt, funct};
    endfunction

    function automatic cpu_bus_pkg::word_t enc_i(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic cpu_bus_pkg::word_t enc_jr(input logic [4:0] rs);
        return enc_r(rs, 5'd0, 5'd0, 5'd0, mips_isa_pkg::fn_jr);
    endfunction

    // One LFSR bit per cycle decides the stall
    always @(negedge clk) begin
        stall_bit <= lfsr[0];
        lfsr      <= lfsr_next(lfsr);
    end

    task automatic build_table();
        logic [31:0] st;
        logic [15:0] imm;
        logic [4:0]  sh_a;
        logic [4:0]  sh_b;
        for (int t = 0; t < NTESTS; t++) begin
            for (int i = 0; i < 8; i++) begin
                prog_tab[t][i] = 32'hfc00_0000;
            end
        end
        // Reference program where 0x20000 < 0x10000 is false
        name_tab[0] = "sltu_6";
        prog_tab[0][0] = enc_i(mips_isa_pkg::op_addiu, 5'd0, T0, 16'h0001);
        prog_tab[0][1] = enc_r(5'd0, T0, T0, 5'd16, mips_isa_pkg::fn_sll);
        prog_tab[0][2] = enc_i(mips_isa_pkg::op_addiu, 5'd0, T1, 16'h0002);
        prog_tab[0][3] = enc_r(5'd0, T1, T1, 5'd16, mips_isa_pkg::fn_sll);
        prog_tab[0][4] = enc_r(T1, T0, V0, 5'd0, mips_isa_pkg::fn_sltu);
        prog_tab[0][5] = enc_jr(5'd0);
        exp_tab[0] = 32'd0;
        name_tab[1] = "sltu_6_swap";
        prog_tab[1] = prog_tab[0];
        prog_tab[1][4] = enc_r(T0, T1, V0, 5'd0, mips_isa_pkg::fn_sltu);
        exp_tab[1] = 32'd1;
        // 100 + (-30) = 70 and then 70 - 100 = -30
        name_tab[2] = "addu_subu";
        prog_tab[2][0] = enc_i(mips_isa_pkg::op_addiu, 5'd0, T0, 16'd100);
        prog_tab[2][1] = enc_i(mips_isa_pkg::op_addiu, 5'd0, T1, 16'hffe2);
        prog_tab[2][2] = enc_r(T0, T1, T2, 5'd0, mips_isa_pkg::fn_addu);
        prog_tab[2][3] = enc_r(T2, T0, V0, 5'd0, mips_isa_pkg::fn_subu);
        prog_tab[2][4] = enc_jr(5'd0);
        exp_tab[2] = 32'hffff_ffe2;
        // ORI with bit 15 set must not spill into the upper half
        name_tab[3] = "and_or_lui";
        prog_tab[3][0] = enc_i(mips_isa_pkg::op_lui, 5'd0, T0, 16'h1234);
        prog_tab[3][1] = enc_i(mips_isa_pkg::op_ori, T0, T0, 16'h5678);
        prog_tab[3][2] = enc_i(mips_isa_pkg::op_addiu, 5'd0, T1, 16'hff00);
        prog_tab[3][3] = enc_r(T0, T1, T2, 5'd0, mips_isa_pkg::fn_and);
        prog_tab[3][4] = enc_i(mips_isa_pkg::op_ori, 5'd0, T3, 16'h80ff);
        prog_tab[3][5] = enc_r(T2, T3, V0, 5'd0, mips_isa_pkg::fn_or);
        prog_tab[3][6] = enc_jr(5'd0);
        exp_tab[3] = 32'h1234_d6ff;
        // -1 < 1 when signed but not when unsigned
        name_tab[4] = "slt_sltu";
        prog_tab[4][0] = enc_i(mips_isa_pkg::op_addiu, 5'd0, T0, 16'hffff);
        prog_tab[4][1] = enc_i(mips_isa_pkg::op_addiu, 5'd0, T1, 16'h0001);
        prog_tab[4][2] = enc_r(T0, T1, T2, 5'd0, mips_isa_pkg::fn_slt);
        prog_tab[4][3] = enc_r(T0, T1, T3, 5'd0, mips_isa_pkg::fn_sltu);
        prog_tab[4][4] = enc_r(5'd0, T2, T2, 5'd1, mips_isa_pkg::fn_sll);
        prog_tab[4][5] = enc_r(T2, T3, V0, 5'd0, mips_isa_pkg::fn_or);
        prog_tab[4][6] = enc_jr(5'd0);
        exp_tab[4] = 32'd2;
        sh_a = 5'd5;
        sh_b = 5'd3;
        name_tab[5] = "sll_srl";
        prog_tab[5][0] = enc_i(mips_isa_pkg::op_lui, 5'd0, T0, 16'h8000);
        prog_tab[5][1] = enc_r(5'd0, T0, T1, sh_a, mips_isa_pkg::fn_srl);
        prog_tab[5][2] = enc_i(mips_isa_pkg::op_addiu, 5'd0, T2, 16'h0055);
        prog_tab[5][3] = enc_r(5'd0, T2, T2, sh_b, mips_isa_pkg::fn_sll);
        prog_tab[5][4] = enc_r(T1, T2, V0, 5'd0, mips_isa_pkg::fn_or);
        prog_tab[5][5] = enc_jr(5'd0);
        exp_tab[5] = (32'h8000_0000 >> sh_a) | (32'h0000_0055 << sh_b);
        // The word at 16 adds 100 but is jumped over
        name_tab[6] = "jr_redirect";
        prog_tab[6][0] = enc_i(mips_isa_pkg::op_addiu, 5'd0, V0, 16'd5);
        prog_tab[6][1] = enc_i(mips_isa_pkg::op_addiu, 5'd0, T0, 16'd20);
        prog_tab[6][2] = enc_jr(T0);
        prog_tab[6][3] = enc_i(mips_isa_pkg::op_addiu, V0, V0, 16'd100);
        prog_tab[6][4] = enc_i(mips_isa_pkg::op_addiu, V0, V0, 16'd7);
        prog_tab[6][5] = enc_jr(5'd0);
        exp_tab[6] = 32'd12;
        name_tab[7] = "rand_addiu";
        exp_tab[7] = 32'd0;
        st = 32'h3716_e9de;
        for (int k = 0; k < 6; k++) begin
            imm = 16'h0000;
            for (int b = 0; b < 16; b++) begin
                imm = {imm[14:0], st[0]};
                st  = lfsr_next(st);
            end
            prog_tab[7][k] = enc_i(mips_isa_pkg::op_addiu, V0, V0, imm);
            exp_tab[7] = exp_tab[7] + {{16{imm[15]}}, imm};
        end
        prog_tab[7][6] = enc_jr(5'd0);
    endtask

    initial begin
        int cyc;
        rst_n     = 1'b0;
        stall_bit = 1'b0;
        load_en   = 1'b0;
        load_addr = 6'd0;
        load_word = 32'h0000_0000;
        exp_v0    = 32'h0000_0000;
        test_name = '0;
        timeouts  = 0;
        build_table();
        @(negedge clk);
        for (int t = 0; t < NTESTS; t++) begin
            test_name = name_tab[t];
            exp_v0    = exp_tab[t];
            // Program goes in at byte address 4 onward
            for (int i = 0; i < 8; i++) begin
                load_en   = 1'b1;
                load_addr = 6'(i + 1);
                load_word = prog_tab[t][i];
                @(negedge clk);
            end
            load_en = 1'b0;
            rst_n   = 1'b0;
            for (int i = 0; i < 4; i++) begin
                @(negedge clk);
            end
            rst_n = 1'b1;
            cyc = 0;
            while (!done && cyc < 2000) begin
                @(negedge clk);
                cyc++;
            end
            if (!done) begin
                $display("error: test %0s timed out, active never fell", test_name);
                timeouts++;
            end
            // Let the checker watch the bus after the halt
            for (int i = 0; i < 10; i++) begin
                @(negedge clk);
            end
        end
        $display("errors: mismatches=%0d halt_errors=%0d bus_errors=%0d timeouts=%0d",
                 mismatches, halt_errors, bus_errors, timeouts);
        if (mismatches == 0 && halt_errors == 0 && bus_errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- mips_isa_pkg.sv
package mips_isa_pkg;

    // Primary opcodes of the supported subset
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;

    // Function codes under the special opcode
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // Register format
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    // Immediate format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // One instruction word, two ways to read it
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

endpackage

//--- run_sim.sh
#!/bin/bash
# Build with Verilator, run, then look for the failure line in the log
verilator --binary --timing -f flist.f --top-module mips_cpu_tb -o sim_bin > build.log 2>&1 \
    && ./obj_dir/sim_bin > sim.log 2>&1 \
    || { echo "build or run failed"; exit 1; }
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

//--- tb_avalon_ram.sv
module tb_avalon_ram (
    input  logic               clk,
    input  cpu_bus_pkg::addr_t address,
    input  logic               read,
    input  logic               stall_bit,
    input  logic               load_en,
    input  logic [5:0]         load_addr,
    input  cpu_bus_pkg::word_t load_word,
    output logic               waitrequest,
    output cpu_bus_pkg::word_t readdata
);

    cpu_bus_pkg::word_t mem [64];

    // Unsupported opcode in the top bits, so stray fetches retire as no-ops
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hfc00_0000 | cpu_bus_pkg::word_t'(i);
        end
    end

    always @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_word;
        end
    end

    // The stall bit comes from the LFSR and changes on the falling edge
    assign waitrequest = stall_bit;
    assign readdata    = read ? mem[address[7:2]] : 32'h0000_0000;

endmodule

//--- tb_checker.sv
module tb_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               active,
    input  logic               read,
    input  logic               waitrequest,
    input  cpu_bus_pkg::addr_t address,
    input  cpu_bus_pkg::word_t register_v0,
    input  cpu_bus_pkg::word_t exp_v0,
    input  logic [127:0]       test_name,
    output logic               done,
    output int                 mismatches,
    output int                 halt_errors,
    output int                 bus_errors
);

    logic               was_active;
    logic               fell;
    logic               prev_read;
    logic               prev_stalled;
    cpu_bus_pkg::addr_t prev_addr;

    initial begin
        done         = 1'b0;
        mismatches   = 0;
        halt_errors  = 0;
        bus_errors   = 0;
        was_active   = 1'b0;
        fell         = 1'b0;
        prev_read    = 1'b0;
        prev_stalled = 1'b0;
        prev_addr    = '0;
    end

    // Sampled on the rising edge before the DUT updates
    always @(posedge clk) begin
        if (!rst_n) begin
            done         <= 1'b0;
            was_active   <= 1'b0;
            fell         <= 1'b0;
            prev_read    <= 1'b0;
            prev_stalled <= 1'b0;
        end else begin
            was_active   <= active;
            prev_read    <= read;
            prev_stalled <= read && waitrequest;
            prev_addr    <= address;
            if (was_active && !active && !fell) begin
                fell <= 1'b1;
                done <= 1'b1;
                if (register_v0 !== exp_v0) begin
                    $display("mismatch: test %0s expected %h actual %h",
                             test_name, exp_v0, register_v0);
                    mismatches <= mismatches + 1;
                end
            end
            // A read still finishing is allowed but a new one is not
            if (fell && read && !prev_read) begin
                $display("error: test %0s issued a read after active fell", test_name);
                halt_errors <= halt_errors + 1;
            end
            // Address and read must hold through a stall
            if (prev_stalled && (!read || address !== prev_addr)) begin
                $display("error: test %0s dropped read or moved address during waitrequest",
                         test_name);
                bus_errors <= bus_errors + 1;
            end
        end
    end

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Half a period high, half low
    always begin
        #(PERIOD / 2);
        clk = ~clk;
    end

endmodule
